/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

	// basic widths
	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] paddr_t;
	typedef logic [31:0] word_t;
	typedef logic [1:0]  plv_t;
	typedef logic [1:0]  mat_t;

	// 0 is fetch, 1 is load/store
	typedef logic port_id_t;

	// current mode register, same field order as the architectural CRMD
	typedef struct packed {
		mat_t datm;
		mat_t datf;
		logic pg;
		logic da;
		logic ie;     // interrupts not modeled here
		plv_t plv;
	} crmd_t;

	// direct-map window
	typedef struct packed {
		logic [2:0] vseg;
		logic [2:0] pseg;
		mat_t       mat;
		logic       plv3;
		logic       plv0;
	} dmw_t;

	// request as seen at a requester port
	typedef struct packed {
		vaddr_t vaddr;
		logic   we;
		word_t  wdata;
	} port_req_t;

	// translated request waiting in a port queue
	typedef struct packed {
		paddr_t paddr;
		logic   uncached;
		logic   fault;
		logic   we;
		word_t  wdata;
	} queue_entry_t;

	// single memory port request
	typedef struct packed {
		port_id_t port;
		paddr_t   paddr;
		logic     uncached;
		logic     we;
		word_t    wdata;
	} mem_req_t;

	// response returned to the requesters
	typedef struct packed {
		port_id_t port;
		paddr_t   paddr;
		logic     uncached;
		logic     fault;
		logic     bus_err;
		word_t    rdata;
	} core_resp_t;

	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_ISSUE = 2'd1,
		ARB_WAIT  = 2'd2,
		ARB_RESP  = 2'd3
	} arb_state_e;

endpackage

`default_nettype wire

/* verilog/addr_trans.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_trans #(
	parameter bit FETCH_PORT = 1'b0
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	input  wire logic                   req_valid_i,
	input  wire core_pkg::port_req_t    req_i,
	input  wire core_pkg::crmd_t        crmd_i,
	input  wire core_pkg::dmw_t         dmw0_i,
	input  wire core_pkg::dmw_t         dmw1_i,
	output logic                        push_o,
	output core_pkg::queue_entry_t      entry_o
);

	import core_pkg::*;

	logic   dmw0_hit;
	logic   dmw1_hit;
	paddr_t paddr;
	mat_t   mat;
	logic   fault;

	// window enabled for this plv and segment matches
	function automatic logic win_hit(dmw_t dmw, plv_t plv, vaddr_t va);
		logic plv_ok;
		plv_ok = (dmw.plv0 && plv == 2'd0) || (dmw.plv3 && plv == 2'd3);
		return plv_ok && (dmw.vseg == va[31:29]);
	endfunction

	assign dmw0_hit = win_hit(dmw0_i, crmd_i.plv, req_i.vaddr);
	assign dmw1_hit = win_hit(dmw1_i, crmd_i.plv, req_i.vaddr);

	always_comb begin
		paddr = req_i.vaddr;
		mat   = '0;
		fault = 1'b0;
		if (crmd_i.da) begin
			mat = FETCH_PORT ? crmd_i.datf : crmd_i.datm;
		end else if (crmd_i.pg && dmw0_hit) begin
			// dmw0 has priority on a double hit
			paddr = {dmw0_i.pseg, req_i.vaddr[28:0]};
			mat   = dmw0_i.mat;
		end else if (crmd_i.pg && dmw1_hit) begin
			paddr = {dmw1_i.pseg, req_i.vaddr[28:0]};
			mat   = dmw1_i.mat;
		end else begin
			// no tlb, so paged miss or no mode at all faults
			fault = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			push_o <= 1'b0;
		end else begin
			push_o <= req_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			entry_o.paddr    <= paddr;
			entry_o.uncached <= (mat == 2'd0);
			entry_o.fault    <= fault;
			// fetch only reads
			entry_o.we       <= FETCH_PORT ? 1'b0 : req_i.we;
			entry_o.wdata    <= req_i.wdata;
		end
	end

endmodule

`default_nettype wire

/* verilog/resp_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_timer #(
	parameter int unsigned MEM_TIMEOUT = 32
) (
	input  wire logic clk,
	input  wire logic rst_n_i,
	input  wire logic run_i,
	output logic      expired_o
);

	localparam int unsigned CNT_W = $clog2(MEM_TIMEOUT + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count <= '0;
		end else if (!run_i) begin
			count <= '0;
		end else if (!expired_o) begin
			// saturate once expired
			count <= count + 1'b1;
		end
	end

	assign expired_o = (count == CNT_W'(MEM_TIMEOUT));

endmodule

`default_nettype wire

/* bus_arbiter/req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
	parameter int unsigned QUEUE_DEPTH = 4
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	input  wire logic                   push_i,
	input  wire core_pkg::queue_entry_t entry_i,
	input  wire logic                   pop_i,
	output logic                        empty_o,
	output core_pkg::queue_entry_t      head_o,
	output logic                        credit_o
);

	import core_pkg::*;

	localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

	queue_entry_t     slots [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_pop  = pop_i && !empty_o;
	assign empty_o = (count == '0);
	assign head_o  = slots[rd_ptr];

	// one credit back per freed slot
	assign credit_o = do_pop;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push_i, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// overflow is prevented by the requester credits
	always_ff @(posedge clk) begin
		if (push_i) begin
			slots[wr_ptr] <= entry_i;
		end
	end

endmodule

`default_nettype wire

/* bus_arbiter/arb_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module arb_fsm (
	input  wire logic                         clk,
	input  wire logic                         rst_n_i,
	input  wire logic [1:0]                   empty_i,
	input  wire core_pkg::queue_entry_t [1:0] head_i,
	output logic [1:0]                        pop_o,
	output logic                              mem_req_valid_o,
	output core_pkg::mem_req_t                mem_req_o,
	input  wire logic                         mem_req_ready_i,
	input  wire logic                         mem_rvalid_i,
	input  wire core_pkg::word_t              mem_rdata_i,
	output logic                              timer_run_o,
	input  wire logic                         timer_expired_i,
	output logic                              resp_valid_o,
	output core_pkg::core_resp_t              resp_o
);

	import core_pkg::*;

	arb_state_e   state;
	arb_state_e   state_nxt;
	port_id_t     last_port;
	port_id_t     sel_port;
	logic         any_req;
	port_id_t     cur_port;
	queue_entry_t cur_entry;
	word_t        rdata_q;
	logic         bus_err_q;

	// prefer the port not served last
	always_comb begin
		sel_port = last_port;
		any_req  = 1'b0;
		if (!empty_i[~last_port]) begin
			sel_port = ~last_port;
			any_req  = 1'b1;
		end else if (!empty_i[last_port]) begin
			any_req  = 1'b1;
		end
	end

	always_comb begin
		pop_o = '0;
		if (state == ARB_IDLE && any_req) begin
			pop_o[sel_port] = 1'b1;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ARB_IDLE: begin
				if (any_req) begin
					// faulted entries skip memory entirely
					state_nxt = head_i[sel_port].fault ? ARB_RESP : ARB_ISSUE;
				end
			end
			ARB_ISSUE: if (mem_req_ready_i) state_nxt = ARB_WAIT;
			ARB_WAIT:  if (mem_rvalid_i || timer_expired_i) state_nxt = ARB_RESP;
			default:   state_nxt = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state     <= ARB_IDLE;
			last_port <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == ARB_IDLE && any_req) begin
				last_port <= sel_port;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ARB_IDLE && any_req) begin
			cur_port  <= sel_port;
			cur_entry <= head_i[sel_port];
			rdata_q   <= '0;
			bus_err_q <= 1'b0;
		end else if (state == ARB_WAIT) begin
			if (mem_rvalid_i) begin
				rdata_q <= cur_entry.we ? '0 : mem_rdata_i;
			end else if (timer_expired_i) begin
				bus_err_q <= 1'b1;
			end
		end
	end

	assign timer_run_o     = (state == ARB_WAIT);
	assign mem_req_valid_o = (state == ARB_ISSUE);
	assign mem_req_o = '{
		port:     cur_port,
		paddr:    cur_entry.paddr,
		uncached: cur_entry.uncached,
		we:       cur_entry.we,
		wdata:    cur_entry.wdata
	};

	assign resp_valid_o = (state == ARB_RESP);
	assign resp_o = '{
		port:     cur_port,
		paddr:    cur_entry.paddr,
		uncached: cur_entry.uncached,
		fault:    cur_entry.fault,
		bus_err:  bus_err_q,
		rdata:    rdata_q
	};

endmodule

`default_nettype wire

/* verilog/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core #(
	parameter int unsigned QUEUE_DEPTH = 4,
	parameter int unsigned MEM_TIMEOUT = 32
) (
	input  wire logic                      clk,
	input  wire logic                      rst_n_i,
	input  wire core_pkg::crmd_t           crmd_i,
	input  wire core_pkg::dmw_t            dmw0_i,
	input  wire core_pkg::dmw_t            dmw1_i,
	input  wire logic [1:0]                req_valid_i,
	input  wire core_pkg::port_req_t [1:0] req_i,
	output logic [1:0]                     credit_o,
	output logic                           mem_req_valid_o,
	output core_pkg::mem_req_t             mem_req_o,
	input  wire logic                      mem_req_ready_i,
	input  wire logic                      mem_rvalid_i,
	input  wire core_pkg::word_t           mem_rdata_i,
	output logic                           resp_valid_o,
	output core_pkg::core_resp_t           resp_o
);

	import core_pkg::*;

	logic [1:0]         push;
	logic [1:0]         pop;
	logic [1:0]         empty;
	queue_entry_t [1:0] trans_entry;
	queue_entry_t [1:0] head;
	logic               timer_run;
	logic               timer_expired;

	// port 0 fetch
	addr_trans #(.FETCH_PORT(1'b1)) u_trans_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.req_valid_i(req_valid_i[0]), .req_i(req_i[0]),
		.crmd_i(crmd_i), .dmw0_i(dmw0_i), .dmw1_i(dmw1_i),
		.push_o(push[0]), .entry_o(trans_entry[0])
	);

	// port 1 load/store
	addr_trans #(.FETCH_PORT(1'b0)) u_trans_d (
		.clk(clk), .rst_n_i(rst_n_i),
		.req_valid_i(req_valid_i[1]), .req_i(req_i[1]),
		.crmd_i(crmd_i), .dmw0_i(dmw0_i), .dmw1_i(dmw1_i),
		.push_o(push[1]), .entry_o(trans_entry[1])
	);

	req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.push_i(push[0]), .entry_i(trans_entry[0]),
		.pop_i(pop[0]), .empty_o(empty[0]), .head_o(head[0]),
		.credit_o(credit_o[0])
	);

	req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_d (
		.clk(clk), .rst_n_i(rst_n_i),
		.push_i(push[1]), .entry_i(trans_entry[1]),
		.pop_i(pop[1]), .empty_o(empty[1]), .head_o(head[1]),
		.credit_o(credit_o[1])
	);

	arb_fsm u_arb (
		.clk(clk), .rst_n_i(rst_n_i),
		.empty_i(empty), .head_i(head), .pop_o(pop),
		.mem_req_valid_o(mem_req_valid_o), .mem_req_o(mem_req_o),
		.mem_req_ready_i(mem_req_ready_i),
		.mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
		.timer_run_o(timer_run), .timer_expired_i(timer_expired),
		.resp_valid_o(resp_valid_o), .resp_o(resp_o)
	);

	resp_timer #(.MEM_TIMEOUT(MEM_TIMEOUT)) u_timer (
		.clk(clk), .rst_n_i(rst_n_i),
		.run_i(timer_run), .expired_o(timer_expired)
	);

endmodule

`default_nettype wire

/* tests/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
	parameter int unsigned QUEUE_DEPTH = 4
) (
	input  wire logic               clk,
	input  wire logic               rst_n_i,
	input  wire logic [1:0]         push_i,
	input  wire logic [1:0]         pop_i,
	input  wire logic [1:0]         credit_i,
	input  wire logic               mem_req_valid_i,
	input  wire logic               mem_req_ready_i,
	input  wire core_pkg::mem_req_t mem_req_i,
	input  wire logic               resp_valid_i
);

	int unsigned occ [2];
	int unsigned fail_cnt = 0;

	// queue occupancy seen from the push strobes and credit pulses
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			occ[0] <= 0;
			occ[1] <= 0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				occ[p] <= occ[p] + push_i[p] - credit_i[p];
			end
		end
	end

	for (genvar g = 0; g < 2; g++) begin : g_port
		assert property (@(posedge clk) disable iff (!rst_n_i)
			push_i[g] |-> occ[g] < QUEUE_DEPTH)
			else begin
				$error("push into a full queue on port %0d", g);
				fail_cnt++;
			end
		// every arbiter pop returns exactly one credit
		assert property (@(posedge clk) disable iff (!rst_n_i)
			credit_i[g] == pop_i[g])
			else begin
				$error("credit pulse and pop disagree on port %0d", g);
				fail_cnt++;
			end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
		else begin
			$error("memory request changed while waiting for ready");
			fail_cnt++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		resp_valid_i |=> !resp_valid_i)
		else begin
			$error("response valid held longer than one cycle");
			fail_cnt++;
		end

endmodule

bind core core_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_checker (
	.clk(clk), .rst_n_i(rst_n_i),
	.push_i(push), .pop_i(pop), .credit_i(credit_o),
	.mem_req_valid_i(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
	.mem_req_i(mem_req_o), .resp_valid_i(resp_valid_o)
);

`default_nettype wire

/* tests/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	import core_pkg::*;

	localparam int unsigned QUEUE_DEPTH = 4;
	localparam int unsigned MEM_TIMEOUT = 32;
	localparam int unsigned NUM_BATCH   = 16;
	localparam int unsigned BATCH_LEN   = 40;
	localparam int unsigned DROP_PCT    = 5;
	localparam int unsigned WAIT_LIMIT  = 20000;

	logic            clk = 1'b0;
	logic            rst_n;
	crmd_t           crmd;
	dmw_t            dmw0;
	dmw_t            dmw1;
	logic [1:0]      req_valid;
	port_req_t [1:0] req;
	logic [1:0]      credit;
	logic            mem_req_valid;
	mem_req_t        mem_req;
	logic            mem_req_ready;
	logic            mem_rvalid;
	word_t           mem_rdata;
	logic            resp_valid;
	core_resp_t      resp;

	word_t        mem [paddr_t];
	queue_entry_t exp_i [$];
	queue_entry_t exp_d [$];
	int unsigned  credits [2];
	int unsigned  sent [2];
	int unsigned  credit_cnt [2];
	int unsigned  err_cnt = 0;
	int unsigned  tmo_cnt = 0;
	int unsigned  assert_cnt = 0;
	int unsigned  n_resp = 0;
	int unsigned  n_fault = 0;
	int unsigned  n_bus_err = 0;
	logic         aborted = 1'b0;
	// one memory transaction in flight
	logic         mem_pending;
	logic         mem_drop;
	word_t        mem_data;
	int unsigned  rsp_delay;

	always #20 clk = ~clk;

	core #(.QUEUE_DEPTH(QUEUE_DEPTH), .MEM_TIMEOUT(MEM_TIMEOUT)) u_core (
		.clk(clk), .rst_n_i(rst_n), .crmd_i(crmd), .dmw0_i(dmw0), .dmw1_i(dmw1),
		.req_valid_i(req_valid), .req_i(req), .credit_o(credit),
		.mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req),
		.mem_req_ready_i(mem_req_ready), .mem_rvalid_i(mem_rvalid),
		.mem_rdata_i(mem_rdata), .resp_valid_o(resp_valid), .resp_o(resp)
	);

	task automatic mismatch(string what, logic [31:0] got, logic [31:0] exp);
		$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		err_cnt++;
	endtask

	task automatic fail_note(string msg);
		$display("%0t: %s", $time, msg);
		err_cnt++;
	endtask

	// contents of words never written
	function automatic word_t fill_word(paddr_t a);
		return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic logic window_hit(dmw_t w, vaddr_t va);
		logic en;
		case (crmd.plv)
			2'd0:    en = w.plv0;
			2'd3:    en = w.plv3;
			default: en = 1'b0;
		endcase
		return en && (w.vseg == va[31:29]);
	endfunction

	function automatic queue_entry_t translate(logic fetch, port_req_t r);
		queue_entry_t e;
		mat_t         m;
		e.paddr = r.vaddr;
		e.fault = 1'b0;
		e.we    = fetch ? 1'b0 : r.we;
		e.wdata = r.wdata;
		m       = 2'd0;
		if (crmd.da) begin
			m = fetch ? crmd.datf : crmd.datm;
		end else if (crmd.pg && window_hit(dmw0, r.vaddr)) begin
			e.paddr = {dmw0.pseg, r.vaddr[28:0]};
			m       = dmw0.mat;
		end else if (crmd.pg && window_hit(dmw1, r.vaddr)) begin
			e.paddr = {dmw1.pseg, r.vaddr[28:0]};
			m       = dmw1.mat;
		end else begin
			e.fault = 1'b1;
		end
		e.uncached = (m == 2'd0);
		return e;
	endfunction

	// segments biased toward the windows and a small offset pool so words repeat
	function automatic vaddr_t pick_vaddr();
		logic [2:0] seg;
		case ($urandom_range(2))
			0:       seg = dmw0.vseg;
			1:       seg = dmw1.vseg;
			default: seg = 3'($urandom);
		endcase
		return {seg, 21'h0, 6'($urandom), 2'b00};
	endfunction

	task automatic randomize_csr();
		crmd = 9'($urandom);
		dmw0 = 10'($urandom);
		dmw1 = 10'($urandom);
		case ($urandom_range(9))
			0:       {crmd.da, crmd.pg} = 2'b00;
			1, 2, 3: {crmd.da, crmd.pg} = 2'b10;
			default: {crmd.da, crmd.pg} = 2'b01;
		endcase
		crmd.plv = $urandom_range(1) ? 2'd3 : 2'd0;
		// double hit now and then
		if ($urandom_range(3) == 0) dmw1.vseg = dmw0.vseg;
	endtask

	task automatic check_resp();
		queue_entry_t e;
		logic         drop;
		word_t        rd;
		if (resp.port ? exp_d.size() == 0 : exp_i.size() == 0) begin
			fail_note($sformatf("response on port %0d with no request outstanding", resp.port));
			return;
		end
		if (resp.port) begin
			e = exp_d.pop_front();
		end else begin
			e = exp_i.pop_front();
		end
		if (e.fault == mem_pending) begin
			fail_note(e.fault ? "faulted request reached memory" : "response without a memory request");
		end
		drop = !e.fault && mem_drop;
		rd   = (e.fault || e.we || drop) ? '0 : mem_data;
		if (resp.paddr !== e.paddr) mismatch("resp paddr", resp.paddr, e.paddr);
		if (resp.uncached !== e.uncached) mismatch("resp uncached", resp.uncached, e.uncached);
		if (resp.fault !== e.fault) mismatch("resp fault", resp.fault, e.fault);
		if (resp.bus_err !== drop) mismatch("resp bus_err", resp.bus_err, drop);
		if (resp.rdata !== rd) mismatch("resp rdata", resp.rdata, rd);
		n_resp++;
		n_fault += e.fault;
		n_bus_err += drop;
		mem_pending = 1'b0;
	endtask

	task automatic run_memory();
		queue_entry_t e;
		mem_rvalid    = 1'b0;
		mem_req_ready = 1'b0;
		if (rsp_delay != 0) begin
			rsp_delay--;
			mem_rvalid = (rsp_delay == 0);
		end
		// old contents come back on writes too
		mem_rdata = mem_rvalid ? mem_data : word_t'($urandom);
		if (mem_req_valid && $urandom_range(3) != 0) begin
			mem_req_ready = 1'b1;
			if (mem_pending) fail_note("second memory request while one is outstanding");
			if (mem_req.port ? exp_d.size() == 0 : exp_i.size() == 0) begin
				fail_note("memory request with no request outstanding");
			end else begin
				e = mem_req.port ? exp_d[0] : exp_i[0];
				if (e.fault) fail_note("faulted request sent to memory");
				if (mem_req.paddr !== e.paddr) mismatch("mem paddr", mem_req.paddr, e.paddr);
				if (mem_req.uncached !== e.uncached) mismatch("mem uncached", mem_req.uncached, e.uncached);
				if (mem_req.we !== e.we) mismatch("mem we", mem_req.we, e.we);
				if (e.we && mem_req.wdata !== e.wdata) mismatch("mem wdata", mem_req.wdata, e.wdata);
			end
			mem_pending = 1'b1;
			mem_drop    = ($urandom_range(99) < DROP_PCT);
			mem_data    = mem.exists(mem_req.paddr) ? mem[mem_req.paddr] : fill_word(mem_req.paddr);
			if (!mem_drop) begin
				if (mem_req.we) mem[mem_req.paddr] = mem_req.wdata;
				rsp_delay = $urandom_range(MEM_TIMEOUT - 1, 1);
			end
		end
	endtask

	task automatic drive_requests(int unsigned rate, int unsigned target);
		port_req_t r;
		for (int p = 0; p < 2; p++) begin
			req_valid[p] = 1'b0;
			if (sent[p] < target && credits[p] != 0 && $urandom_range(99) < rate) begin
				r.vaddr      = pick_vaddr();
				r.we         = $urandom_range(1);
				r.wdata      = $urandom;
				req[p]       = r;
				req_valid[p] = 1'b1;
				credits[p]--;
				sent[p]++;
				if (p == 0) begin
					exp_i.push_back(translate(1'b1, r));
				end else begin
					exp_d.push_back(translate(1'b0, r));
				end
			end
		end
	endtask

	task automatic cycle(int unsigned rate, int unsigned target);
		@(negedge clk);
		if (resp_valid) check_resp();
		for (int p = 0; p < 2; p++) begin
			if (credit[p]) begin
				credits[p]++;
				credit_cnt[p]++;
				if (credits[p] > QUEUE_DEPTH) fail_note("more credits returned than granted");
			end
		end
		run_memory();
		drive_requests(rate, target);
	endtask

	task automatic run_batch(int unsigned rate, int unsigned target);
		int unsigned n_send;
		int unsigned n_drain;
		n_send  = 0;
		n_drain = 0;
		while ((sent[0] < target || sent[1] < target) && n_send < WAIT_LIMIT) begin
			cycle(rate, target);
			n_send++;
		end
		while ((exp_i.size() != 0 || exp_d.size() != 0 || credits[0] != QUEUE_DEPTH ||
				credits[1] != QUEUE_DEPTH) && n_drain < WAIT_LIMIT) begin
			cycle(0, target);
			n_drain++;
		end
		if (n_send >= WAIT_LIMIT || n_drain >= WAIT_LIMIT) begin
			$display("%0t: timeout, requests were not all answered within %0d cycles",
				$time, WAIT_LIMIT);
			tmo_cnt++;
			aborted = 1'b1;
		end
	endtask

	initial begin
		void'($urandom(32'hf324_2e03));
		rst_n         = 1'b0;
		crmd          = '0;
		dmw0          = '0;
		dmw1          = '0;
		req_valid     = '0;
		req           = '0;
		mem_req_ready = 1'b0;
		mem_rvalid    = 1'b0;
		mem_rdata     = '0;
		mem_pending   = 1'b0;
		mem_drop      = 1'b0;
		mem_data      = '0;
		rsp_delay     = 0;
		credits       = '{QUEUE_DEPTH, QUEUE_DEPTH};
		sent          = '{0, 0};
		credit_cnt    = '{0, 0};
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		// odd batches keep both ports saturated
		for (int b = 0; b < NUM_BATCH && !aborted; b++) begin
			randomize_csr();
			run_batch((b % 2) ? 100 : 50, (b + 1) * BATCH_LEN);
		end
		for (int p = 0; p < 2; p++) begin
			if (credit_cnt[p] != sent[p]) mismatch("credit pulses", credit_cnt[p], sent[p]);
		end
		if (n_fault == 0 || n_bus_err == 0) fail_note("no translation fault or no bus error seen");
		// failures of the bound assertions
		assert_cnt = u_core.u_checker.fail_cnt;
		$display("responses %0d, faults %0d, bus errors %0d, errors %0d, assertions %0d, timeouts %0d",
			n_resp, n_fault, n_bus_err, err_cnt, assert_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0 && assert_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/core_pkg.sv
verilog/addr_trans.sv
verilog/resp_timer.sv
bus_arbiter/req_queue.sv
bus_arbiter/arb_fsm.sv
verilog/core.sv
tests/core_checker.sv
tests/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - common/core_pkg.sv
  - verilog/addr_trans.sv
  - verilog/resp_timer.sv
  - bus_arbiter/req_queue.sv
  - bus_arbiter/arb_fsm.sv
  - verilog/core.sv
  - target: test
    files:
      - tests/core_checker.sv
      - tests/core_tb.sv
